//--- common/boardRegPkg.sv
// Board register bus map and data widths
// Used by the sequencer to form addresses and by the board registers to decode them
`default_nettype none

package boardRegPkg;

   // Register bus widths
   localparam int RegAddrWidth = 8;
   localparam int RegDataWidth = 32;

   // MSB of a host DAC quadlet is its valid flag
   localparam int DacValidBit = RegDataWidth - 1;

   // DAC payload bits below the valid flag
   localparam int DacQuadWidth = RegDataWidth - 1;

   // Only the low 20 bits of the power-control quadlet are kept
   // Upper bits would reach reboot and other board functions
   localparam int CtrlWidth = 20;

   // Channel DAC register: channel number plus one in the high nibble,
   // this offset in the low nibble
   localparam logic [3:0] DacCtrlOffset = 4'h1;

   // Power-control register lives at address 0
   localparam logic [RegAddrWidth-1:0] PowerCtrlAddr = 8'h00;

endpackage

`default_nettype wire

//--- common/rtInterfaces.sv
// Interfaces inside the real-time write path
// rtBufferIf joins the block buffer to the sequencer, regWriteIf is the board register bus
`timescale 1ns/1ns
`default_nettype none

interface rtBufferIf
   import rtTypesPkg::*, boardRegPkg::*;
();
   logic [NumChannels-1:0]    dacValid;
   logic [ChanIndexWidth-1:0] readIndex;
   logic [DacQuadWidth-1:0]   dacQuad;
   logic                      clearValid;
   logic [CtrlWidth-1:0]      ctrlQuad;
   logic                      clearCtrl;
   logic                      blockReady;

   // Buffer side
   modport store (
      input  readIndex, clearValid, clearCtrl,
      output dacValid, dacQuad, ctrlQuad, blockReady
   );

   // Sequencer side
   modport control (
      input  dacValid, dacQuad, ctrlQuad, blockReady,
      output readIndex, clearValid, clearCtrl
   );
endinterface

interface regWriteIf
   import boardRegPkg::*;
();
   logic                    writeEn;
   logic                    blockStart;
   logic                    regWen;
   logic                    blockWen;
   logic [RegAddrWidth-1:0] regAddr;
   logic [RegDataWidth-1:0] regData;

   modport initiator (
      output writeEn, blockStart, regWen, blockWen, regAddr, regData
   );

   modport target (
      input writeEn, blockStart, regWen, blockWen, regAddr, regData
   );
endinterface

`default_nettype wire

//--- common/rtTypesPkg.sv
// Shared types for the real-time block write path
// Holds the sequencer state encoding, the channel count and the host block layout
// Imported by the buffer, the sequencer, the board registers and the top level
`default_nettype none

package rtTypesPkg;

   // Number of DAC channels carried in one real-time block
   localparam int NumChannels = 4;

   // Bits needed to select one channel
   localparam int ChanIndexWidth = $clog2(NumChannels);

   // Length of each timing gap on the register bus, in clock cycles
   localparam int DefaultGapCycles = 4;

   // Host block address width, addresses 0 to 4 are in use
   localparam int HostAddrWidth = 3;

   // Host address of the power-control quadlet, which also starts the block
   localparam logic [HostAddrWidth-1:0] CtrlQuadAddr = 3'd4;

   // Sequencer states
   // Each state names what the sequencer shows on the register bus in that cycle
   typedef enum logic [2:0] {
      Idle       = 3'd0,
      WriteStart = 3'd1,
      DacWrite   = 3'd2,
      DacGap     = 3'd3,
      BlockWait  = 3'd4,
      QuadGap    = 3'd5,
      QuadWrite  = 3'd6
   } rtState;

endpackage

`default_nettype wire

//--- filelist.f
common/rtTypesPkg.sv
common/boardRegPkg.sv
common/rtInterfaces.sv
rtWrite/rtBlockBuffer.sv
rtWrite/rtWriteSequencer.sv
hdl/boardRegisters.sv
hdl/rtWriteTop.sv
tests/tbClock.sv
tests/rtWrite_assertions.sv
tests/rtWriteTb.sv

//--- hdl/boardRegisters.sv
// Board register target on the register bus
// Per-channel DAC holding registers commit together to the outputs on a block write
// Also holds the power-control register
`timescale 1ns/1ns
`default_nettype none

module boardRegisters
   import rtTypesPkg::*, boardRegPkg::*;
#(
   parameter int DacWidth = 16
)
(
   input wire                                 clk,
   input wire                                 reset,
   regWriteIf.target                          bus,
   output logic [NumChannels-1:0][DacWidth-1:0] dacValues,
   output logic                               dacUpdate,
   output logic [CtrlWidth-1:0]               powerControl
);

   logic [NumChannels-1:0][DacWidth-1:0] dacHold;

   logic [3:0] chanField;
   logic       dacAddrHit;
   logic       blockCommit;
   logic       powerWrite;

   // Channel field is the high nibble, one-based
   assign chanField   = bus.regAddr[RegAddrWidth-1:4];
   assign dacAddrHit  = bus.regWen && (bus.regAddr[3:0] == DacCtrlOffset);
   // Commit only when blockWen comes without a register write
   assign blockCommit = bus.blockWen && !bus.regWen;
   assign powerWrite  = bus.regWen && bus.blockWen && (bus.regAddr == PowerCtrlAddr);

   // Holding registers load the low DacWidth bits of the write data
   always_ff @(posedge clk)
   begin
      if (dacAddrHit)
      begin
         for (int ch = 0; ch < NumChannels; ch++)
         begin
            if (chanField == 4'(ch + 1))
            begin
               dacHold[ch] <= bus.regData[DacWidth-1:0];
            end
         end
      end
   end

   // Outputs and update pulse
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         dacValues    <= '0;
         dacUpdate    <= 1'b0;
         powerControl <= '0;
      end
      else
      begin
         dacUpdate <= blockCommit;
         // All axes move together, unwritten ones reload their old value
         if (blockCommit)
         begin
            dacValues <= dacHold;
         end
         if (powerWrite)
         begin
            powerControl <= bus.regData[CtrlWidth-1:0];
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/rtWriteTop.sv
// Top level of the real-time block write path
// Host link strobes enter here, DAC and power-control outputs leave here
// GapCycles and DacWidth are set here and passed down
`timescale 1ns/1ns
`default_nettype none

module rtWriteTop
   import rtTypesPkg::*, boardRegPkg::*;
#(
   parameter int GapCycles = DefaultGapCycles,
   parameter int DacWidth  = 16
)
(
   input wire                                 clk,
   input wire                                 reset,
   // Host side
   input wire                                 rtWriteEn,
   input wire [HostAddrWidth-1:0]             rtWriteAddr,
   input wire [RegDataWidth-1:0]              rtWriteData,
   output logic                               rtBusy,
   // Board side
   output logic [NumChannels-1:0][DacWidth-1:0] dacValues,
   output logic                               dacUpdate,
   output logic [CtrlWidth-1:0]               powerControl
);

   rtBufferIf rtBufLink ();
   regWriteIf regBus ();

   logic hostWriteEn;

   // Host writes are dropped while a sequence runs
   assign hostWriteEn = rtWriteEn && !rtBusy;

   rtBlockBuffer blockBuf0 (
      .clk         (clk),
      .reset       (reset),
      .rtWriteEn   (hostWriteEn),
      .rtWriteAddr (rtWriteAddr),
      .rtWriteData (rtWriteData),
      .rtBuf       (rtBufLink.store)
   );

   rtWriteSequencer #(
      .GapCycles (GapCycles)
   ) seq0 (
      .clk    (clk),
      .reset  (reset),
      .rtBuf  (rtBufLink.control),
      .bus    (regBus.initiator),
      .rtBusy (rtBusy)
   );

   boardRegisters #(
      .DacWidth (DacWidth)
   ) regs0 (
      .clk          (clk),
      .reset        (reset),
      .bus          (regBus.target),
      .dacValues    (dacValues),
      .dacUpdate    (dacUpdate),
      .powerControl (powerControl)
   );

endmodule

`default_nettype wire

//--- rtWrite/rtBlockBuffer.sv
// Local store for one real-time block from the host link
// Keeps four DAC quadlets with valid flags and the power-control quadlet
// Host strobes reach it only while the sequencer is idle
`timescale 1ns/1ns
`default_nettype none

module rtBlockBuffer
   import rtTypesPkg::*, boardRegPkg::*;
(
   input wire                     clk,
   input wire                     reset,
   input wire                     rtWriteEn,
   input wire [HostAddrWidth-1:0] rtWriteAddr,
   input wire [RegDataWidth-1:0]  rtWriteData,
   rtBufferIf.store               rtBuf
);

   logic [NumChannels-1:0]    validFlags;
   logic                      blockReadyReg;
   logic [DacQuadWidth-1:0]   dacQuadMem [NumChannels];
   logic [CtrlWidth-1:0]      ctrlReg;

   logic                      dacWrite;
   logic                      ctrlWrite;
   logic [ChanIndexWidth-1:0] writeIndex;

   // Address decode of the host strobe
   // Addresses 5 to 7 fall through and are dropped
   assign dacWrite   = rtWriteEn && (rtWriteAddr < HostAddrWidth'(NumChannels));
   assign ctrlWrite  = rtWriteEn && (rtWriteAddr == CtrlQuadAddr);
   assign writeIndex = rtWriteAddr[ChanIndexWidth-1:0];

   // Valid flags and block start strobe
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         validFlags    <= '0;
         blockReadyReg <= 1'b0;
      end
      else
      begin
         // One-cycle strobe in the cycle the control quadlet is stored
         blockReadyReg <= ctrlWrite;
         // Sequencer consumes the flag of the channel it is reading
         if (rtBuf.clearValid)
         begin
            validFlags[rtBuf.readIndex] <= 1'b0;
         end
         if (dacWrite)
         begin
            validFlags[writeIndex] <= rtWriteData[DacValidBit];
         end
      end
   end

   // DAC payload and control quadlet
   always_ff @(posedge clk)
   begin
      if (dacWrite)
      begin
         dacQuadMem[writeIndex] <= rtWriteData[DacQuadWidth-1:0];
      end
      if (ctrlWrite)
      begin
         ctrlReg <= rtWriteData[CtrlWidth-1:0];
      end
      else if (rtBuf.clearCtrl)
      begin
         // Control quadlet is single-use once written to the board
         ctrlReg <= '0;
      end
   end

   assign rtBuf.dacValid   = validFlags;
   assign rtBuf.dacQuad    = dacQuadMem[rtBuf.readIndex];
   assign rtBuf.ctrlQuad   = ctrlReg;
   assign rtBuf.blockReady = blockReadyReg;

endmodule

`default_nettype wire

//--- rtWrite/rtWriteSequencer.sv
// Replays a stored real-time block as timed writes on the board register bus
// Block start, four DAC writes with gaps, block commit, then the power-control quadlet
// GapCycles sets the length of every gap and must be 2 or more
`timescale 1ns/1ns
`default_nettype none

module rtWriteSequencer
   import rtTypesPkg::*, boardRegPkg::*;
#(
   parameter int GapCycles = DefaultGapCycles
)
(
   input wire           clk,
   input wire           reset,
   rtBufferIf.control   rtBuf,
   regWriteIf.initiator bus,
   output logic         rtBusy
);

   // Counter reaches GapCycles in BlockWait, so it needs one extra value
   localparam int CountWidth = $clog2(GapCycles + 1);
   localparam logic [CountWidth-1:0] LastGap = CountWidth'(GapCycles - 1);
   localparam logic [CountWidth-1:0] CommitCount = CountWidth'(GapCycles);
   localparam logic [ChanIndexWidth-1:0] LastChan = ChanIndexWidth'(NumChannels - 1);

   rtState                    state;
   logic [CountWidth-1:0]     gapCount;
   logic [ChanIndexWidth-1:0] chanIndex;

   logic                      anyValid;
   logic [3:0]                chanNibble;
   logic [RegAddrWidth-1:0]   dacAddr;

   assign anyValid = |rtBuf.dacValid;

   // DAC register address: channel number plus one, then the DAC offset
   assign chanNibble = 4'(chanIndex) + 4'd1;
   assign dacAddr    = {chanNibble, DacCtrlOffset};

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state     <= Idle;
         gapCount  <= '0;
         chanIndex <= '0;
      end
      else
      begin
         case (state)
            Idle:
            begin
               gapCount  <= '0;
               chanIndex <= '0;
               if (rtBuf.blockReady)
               begin
                  // No DAC to update, go straight to the quadlet write
                  state <= anyValid ? WriteStart : QuadWrite;
               end
            end

            WriteStart:
            begin
               // Block start is held for GapCycles cycles
               if (gapCount == LastGap)
               begin
                  gapCount <= '0;
                  state    <= DacWrite;
               end
               else
               begin
                  gapCount <= gapCount + 1'b1;
               end
            end

            DacWrite:
            begin
               // Write cycle counts as the first of GapCycles per channel
               gapCount <= CountWidth'(1);
               state    <= DacGap;
            end

            DacGap:
            begin
               if (gapCount == LastGap)
               begin
                  gapCount <= '0;
                  if (chanIndex == LastChan)
                  begin
                     state <= BlockWait;
                  end
                  else
                  begin
                     chanIndex <= chanIndex + 1'b1;
                     state     <= DacWrite;
                  end
               end
               else
               begin
                  gapCount <= gapCount + 1'b1;
               end
            end

            BlockWait:
            begin
               // GapCycles idle cycles, then the commit cycle at CommitCount
               if (gapCount == CommitCount)
               begin
                  gapCount <= '0;
                  // Zero control quadlet is skipped after a DAC block
                  state    <= (rtBuf.ctrlQuad != '0) ? QuadGap : Idle;
               end
               else
               begin
                  gapCount <= gapCount + 1'b1;
               end
            end

            QuadGap:
            begin
               if (gapCount == LastGap)
               begin
                  gapCount <= '0;
                  state    <= QuadWrite;
               end
               else
               begin
                  gapCount <= gapCount + 1'b1;
               end
            end

            QuadWrite:
            begin
               state <= Idle;
            end

            default:
            begin
               state <= Idle;
            end
         endcase
      end
   end

   // Bus strobes decode straight from the state
   assign bus.writeEn    = (state != Idle);
   assign bus.blockStart = (state == WriteStart);
   // DAC write is real only when the channel carried a valid flag
   assign bus.regWen     = ((state == DacWrite) && rtBuf.dacValid[chanIndex])
                           || (state == QuadWrite);
   // Commit pulse alone, or together with regWen for the power-control write
   assign bus.blockWen   = ((state == BlockWait) && (gapCount == CommitCount))
                           || (state == QuadWrite);
   assign bus.regAddr    = (state == QuadWrite) ? PowerCtrlAddr : dacAddr;
   // Valid flag is stripped from the DAC data
   assign bus.regData    = (state == QuadWrite) ? RegDataWidth'(rtBuf.ctrlQuad)
                                                : {1'b0, rtBuf.dacQuad};

   // Buffer handshake
   assign rtBuf.readIndex  = chanIndex;
   assign rtBuf.clearValid = (state == DacWrite);
   assign rtBuf.clearCtrl  = (state == QuadWrite);

   // Busy covers the blockReady cycle, before the state leaves Idle
   assign rtBusy = rtBuf.blockReady || (state != Idle);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Build and run the rtWriteTb simulation with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module rtWriteTb -o rtWriteSim || { echo "Build failed"; exit 1; }

./obj_dir/rtWriteSim | tee /dev/stderr | grep -x "Testbench passed" > /dev/null \
   && echo "Simulation PASS" \
   || { echo "Simulation FAIL"; exit 1; }

//--- tests/rtWriteGolden.txt
// kind_addr_data_dac0_dac1_dac2_dac3_power_pulses, all hex
// kind 1 is a host write of data to addr, kind 2 checks the outputs once rtBusy falls
1_0_81231234_0000_0000_0000_0000_00000_00
1_1_80025678_0000_0000_0000_0000_00000_00
1_2_80009ABC_0000_0000_0000_0000_00000_00
1_3_8007DEF0_0000_0000_0000_0000_00000_00
1_4_00000000_0000_0000_0000_0000_00000_00
2_0_00000000_1234_5678_9ABC_DEF0_00000_01
1_4_FFF5A5A5_0000_0000_0000_0000_00000_00
2_0_00000000_1234_5678_9ABC_DEF0_5A5A5_00
1_1_80000042_0000_0000_0000_0000_00000_00
1_2_0000BEEF_0000_0000_0000_0000_00000_00
1_3_80000777_0000_0000_0000_0000_00000_00
1_4_00012345_0000_0000_0000_0000_00000_00
2_0_00000000_1234_0042_9ABC_0777_12345_01
1_4_00000000_0000_0000_0000_0000_00000_00
2_0_00000000_1234_0042_9ABC_0777_00000_00
1_0_80001001_0000_0000_0000_0000_00000_00
1_1_80002002_0000_0000_0000_0000_00000_00
1_2_80003003_0000_0000_0000_0000_00000_00
1_3_80004004_0000_0000_0000_0000_00000_00
1_4_000F0001_0000_0000_0000_0000_00000_00
1_0_8000DEAD_0000_0000_0000_0000_00000_00
1_1_8000BEEF_0000_0000_0000_0000_00000_00
1_4_00000ABC_0000_0000_0000_0000_00000_00
2_0_00000000_1001_2002_3003_4004_F0001_01
1_4_00000003_0000_0000_0000_0000_00000_00
2_0_00000000_1001_2002_3003_4004_00003_00

//--- tests/rtWriteTb.sv
// Testbench for the real-time block write path
// Replays host writes from the golden file and checks DAC, power-control and update pulses
// A check line waits for rtBusy to fall before it compares
`timescale 1ns/1ns
`default_nettype none

module rtWriteTb
   import rtTypesPkg::*, boardRegPkg::*;
();

   localparam int GapCycles     = 4;
   localparam int DacWidth      = 16;
   localparam int ClockPeriod   = 4;
   localparam int MaxLines      = 64;
   localparam int CyclesPerLine = 8 * GapCycles + 20;
   // kind, addr, data, four DAC fields, power, pulse count
   localparam int RecWidth      = 132;

   logic                                 clk;
   logic                                 reset;
   logic                                 rtWriteEn;
   logic [HostAddrWidth-1:0]             rtWriteAddr;
   logic [RegDataWidth-1:0]              rtWriteData;
   logic                                 rtBusy;
   logic [NumChannels-1:0][DacWidth-1:0] dacValues;
   logic                                 dacUpdate;
   logic [CtrlWidth-1:0]                 powerControl;

   logic [RecWidth-1:0] golden [0:MaxLines-1];
   int lineCount   = 0;
   int errors      = 0;
   int checks      = 0;
   int pulseTotal  = 0;
   int pulsesSeen  = 0;

   tbClock #(
      .HalfPeriod (ClockPeriod / 2)
   ) clockGen0 (
      .clk   (clk),
      .reset (reset)
   );

   rtWriteTop #(
      .GapCycles (GapCycles),
      .DacWidth  (DacWidth)
   ) dut0 (
      .clk          (clk),
      .reset        (reset),
      .rtWriteEn    (rtWriteEn),
      .rtWriteAddr  (rtWriteAddr),
      .rtWriteData  (rtWriteData),
      .rtBusy       (rtBusy),
      .dacValues    (dacValues),
      .dacUpdate    (dacUpdate),
      .powerControl (powerControl)
   );

   // Count dacUpdate pulses at the falling edge, where outputs are stable
   always @(negedge clk)
   begin
      if (!reset && dacUpdate)
      begin
         pulseTotal <= pulseTotal + 1;
      end
   end

   // One host strobe after a short random idle gap
   task automatic driveHostWrite(input logic [3:0] addr, input logic [31:0] data);
      int idleCycles;
      idleCycles = $urandom % 3;
      repeat (idleCycles) @(posedge clk);
      @(posedge clk);
      rtWriteEn   <= 1'b1;
      rtWriteAddr <= addr[HostAddrWidth-1:0];
      rtWriteData <= data;
      @(posedge clk);
      rtWriteEn   <= 1'b0;
   endtask

   // Wait for the sequence to end, then compare all board outputs
   task automatic checkOutputs(input logic [RecWidth-1:0] rec);
      int ch;
      int pulseDelta;
      logic [DacWidth-1:0]  expDac;
      logic [CtrlWidth-1:0] expPower;
      logic [7:0]           expPulses;
      @(negedge clk);
      // Block started by the previous line is still running here
      checks++;
      assert (rtBusy === 1'b1)
      else
      begin
         errors++;
         $display("FAILED rtBusy got 0x%h expected 0x1", rtBusy);
      end
      while (rtBusy) @(negedge clk);
      // Let the last dacUpdate pulse end and be counted
      repeat (2) @(negedge clk);
      for (ch = 0; ch < NumChannels; ch++)
      begin
         expDac = rec[91 - DacWidth * ch -: DacWidth];
         checks++;
         assert (dacValues[ch] === expDac)
         else
         begin
            errors++;
            $display("FAILED dacValues[%0d] got 0x%h expected 0x%h", ch, dacValues[ch], expDac);
         end
      end
      expPower = rec[27:8];
      checks++;
      assert (powerControl === expPower)
      else
      begin
         errors++;
         $display("FAILED powerControl got 0x%h expected 0x%h", powerControl, expPower);
      end
      expPulses  = rec[7:0];
      pulseDelta = pulseTotal - pulsesSeen;
      pulsesSeen = pulseTotal;
      checks++;
      assert (pulseDelta == int'(expPulses))
      else
      begin
         errors++;
         $display("FAILED dacUpdate pulses got 0x%h expected 0x%h", pulseDelta, expPulses);
      end
   endtask

   // Watchdog sized from the number of golden lines
   initial
   begin
      wait (lineCount > 0);
      repeat (lineCount * CyclesPerLine) @(posedge clk);
      $display("Watchdog timeout after %0d clock cycles, sequence never went idle",
               lineCount * CyclesPerLine);
      $display("Testbench failed");
      $finish;
   end

   initial
   begin
      int idx;
      logic [RecWidth-1:0] rec;
      rtWriteEn   = 1'b0;
      rtWriteAddr = '0;
      rtWriteData = '0;
      void'($urandom(67));
      for (idx = 0; idx < MaxLines; idx++)
      begin
         golden[idx] = '0;
      end
      $readmemh("tests/rtWriteGolden.txt", golden);
      // Records are contiguous, kind zero marks the end
      idx = 0;
      while ((idx < MaxLines) && (golden[idx][131:128] != 4'h0))
      begin
         idx++;
      end
      lineCount = idx;
      if (lineCount == 0)
      begin
         errors++;
         $display("No stimulus lines were found in the golden file");
      end
      @(posedge clk);
      while (reset !== 1'b0) @(posedge clk);
      for (idx = 0; idx < lineCount; idx++)
      begin
         rec = golden[idx];
         case (rec[131:128])
            4'h1: driveHostWrite(rec[127:124], rec[123:92]);
            4'h2: checkOutputs(rec);
            default:
            begin
               errors++;
               $display("Golden line %0d has an unknown record kind %0h", idx, rec[131:128]);
            end
         endcase
      end
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
      begin
         $display("Testbench passed");
      end
      else
      begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/rtWrite_assertions.sv
// Protocol checks on the register bus driven by the write sequencer
// Bound into every rtWriteSequencer instance
`timescale 1ns/1ns
`default_nettype none

module rtWriteAssertions (
   input wire clk,
   input wire reset,
   input wire writeEn,
   input wire blockStart,
   input wire regWen,
   input wire blockWen
);

   // No register write during the block start window
   noWriteInStart: assert property (@(posedge clk) disable iff (reset)
      blockStart |-> !regWen)
      else $error("regWen high while blockStart is high");

   // A commit pulse on its own is exactly one cycle long
   commitOneCycle: assert property (@(posedge clk) disable iff (reset)
      (blockWen && !regWen) |=> !blockWen)
      else $error("blockWen commit pulse longer than one cycle");

   // writeEn only drops right after the last write of a sequence
   writeEnHeld: assert property (@(posedge clk) disable iff (reset)
      $fell(writeEn) |-> $past(regWen || blockWen))
      else $error("writeEn dropped before the final write of the sequence");

endmodule

bind rtWriteSequencer rtWriteAssertions assertions0 (
   .clk        (clk),
   .reset      (reset),
   .writeEn    (bus.writeEn),
   .blockStart (bus.blockStart),
   .regWen     (bus.regWen),
   .blockWen   (bus.blockWen)
);

`default_nettype wire

//--- tests/tbClock.sv
// Clock and reset source for the testbench
// 4 ns clock, synchronous active-high reset held for the first two rising edges
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
   parameter int HalfPeriod  = 2,
   parameter int ResetCycles = 2
)
(
   output logic clk,
   output logic reset
);

   initial
   begin
      clk = 1'b0;
      forever #HalfPeriod clk = ~clk;
   end

   // Reset released with an NBA so it changes cleanly after the edge
   initial
   begin
      reset = 1'b1;
      repeat (ResetCycles) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

`default_nettype wire
